/* logic/mips_id_settings.svh */
`ifndef MIPS_ID_SETTINGS_SVH
`define MIPS_ID_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Number of general purpose registers, r0 included.
`define MIPS_ID_NREG 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt coprocessor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Interrupt sources, masked by ie bits 1 and up.
`define MIPS_ID_NIRQ 8
`define MIPS_ID_NBIT_IRQ 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Syscall argument registers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Service number in v0, argument in a0.
`define MIPS_ID_SYSCALL_RA 5'd2
`define MIPS_ID_SYSCALL_RB 5'd4

`endif

/* logic/mips_id_pkg.sv */
`default_nettype none

package mips_id_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation encodings.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    // Next-PC kind.
    typedef enum logic [2:0] {
        WTG_SEQ, WTG_J, WTG_JR, WTG_BEQ, WTG_BNE, WTG_ERET
    } wtg_op_e;

    typedef enum logic [1:0] {DM_NONE, DM_LW, DM_SW} dm_op_e;

    typedef enum logic [1:0] {RC0_NONE, RC0_ENTER, RC0_RETURN} rc0_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath selects.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {REQW_NONE, REQW_RD, REQW_RT, REQW_R31} reqw_sel_e;

    typedef enum logic [1:0] {DATAW_ALU, DATAW_MEM, DATAW_PC8, DATAW_RC0} dataw_sel_e;

    typedef enum logic [1:0] {ALUY_REGB, ALUY_SEXT, ALUY_ZEXT, ALUY_SHAMT} aluy_sel_e;

    // Control bundle for the later stages.
    typedef struct packed {
        logic       rf_ra;
        logic       rf_rb;
        logic       rf_we;
        rc0_op_e    rc0_op;
        logic       rc0_ie_we;
        logic       rc0_epc_we;
        alu_op_e    alu_op;
        wtg_op_e    wtg_op;
        dm_op_e     dm_op;
        logic       syscall_en;
        dataw_sel_e mux_rf_data_w;
        aluy_sel_e  mux_alu_data_y;
        logic       sel_rc0_epc;
    } ctrl_t;

    // Write-back into the register file.
    typedef struct packed {
        logic        we;
        logic [4:0]  req;
        logic [31:0] data;
    } rf_wr_t;

    // Write-back into rc0.
    typedef struct packed {
        rc0_op_e     op;
        logic        ie_we;
        logic        epc_we;
        logic [31:0] ie;
        logic [31:0] epc;
    } rc0_wr_t;

endpackage

`default_nettype wire

/* logic/ctrl_decode.sv */
`default_nettype none
`timescale 1ns/1ns

module ctrl_decode import mips_id_pkg::*; (
    input  wire logic [31:0] inst,
    output logic [4:0]       rs,
    output logic [4:0]       rt,
    output logic [4:0]       rd,
    output logic [4:0]       shamt,
    output logic [15:0]      imm16,
    output ctrl_t            ctl,
    output reqw_sel_e        reqw_sel,
    output logic             is_jump,
    output logic             is_branch
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode and funct encodings.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_COP0    = 6'h10;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_ERET    = 6'h18;

    // COP0 sub-op lives in the rs field.
    localparam logic [4:0] CP0_MF     = 5'h00;
    localparam logic [4:0] CP0_MT     = 5'h04;
    localparam logic [4:0] CP0_CO     = 5'h10;

    logic [5:0] opcode;
    logic [5:0] funct;

    // Field split.
    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];
    assign imm16  = inst[15:0];

    always_comb begin
        ctl = '0;
        reqw_sel = REQW_NONE;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
                        ctl.rf_ra = 1'b1;
                        ctl.rf_rb = 1'b1;
                        ctl.rf_we = 1'b1;
                        reqw_sel = REQW_RD;
                        case (funct)
                            FN_SUB:  ctl.alu_op = ALU_SUB;
                            FN_AND:  ctl.alu_op = ALU_AND;
                            FN_OR:   ctl.alu_op = ALU_OR;
                            FN_SLT:  ctl.alu_op = ALU_SLT;
                            default: ctl.alu_op = ALU_ADD;
                        endcase
                    end
                    FN_SLL, FN_SRL: begin
                        // Shift source is rt, carried on port b.
                        ctl.rf_rb = 1'b1;
                        ctl.rf_we = 1'b1;
                        reqw_sel = REQW_RD;
                        ctl.alu_op = (funct == FN_SRL) ? ALU_SRL : ALU_SLL;
                        ctl.mux_alu_data_y = ALUY_SHAMT;
                    end
                    FN_JR: begin
                        ctl.rf_ra = 1'b1;
                        ctl.wtg_op = WTG_JR;
                    end
                    FN_SYSCALL: begin
                        ctl.rf_ra = 1'b1;
                        ctl.rf_rb = 1'b1;
                        ctl.syscall_en = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_LW: begin
                ctl.rf_ra = 1'b1;
                ctl.rf_we = 1'b1;
                reqw_sel = REQW_RT;
                case (opcode)
                    OP_ANDI: begin
                        ctl.alu_op = ALU_AND;
                        ctl.mux_alu_data_y = ALUY_ZEXT;
                    end
                    OP_ORI: begin
                        ctl.alu_op = ALU_OR;
                        ctl.mux_alu_data_y = ALUY_ZEXT;
                    end
                    default: begin
                        ctl.alu_op = ALU_ADD;
                        ctl.mux_alu_data_y = ALUY_SEXT;
                    end
                endcase
                if (opcode == OP_LW) begin
                    ctl.dm_op = DM_LW;
                    ctl.mux_rf_data_w = DATAW_MEM;
                end
            end
            OP_LUI: begin
                ctl.rf_we = 1'b1;
                reqw_sel = REQW_RT;
                ctl.alu_op = ALU_LUI;
                ctl.mux_alu_data_y = ALUY_ZEXT;
            end
            OP_SW: begin
                ctl.rf_ra = 1'b1;
                ctl.rf_rb = 1'b1;
                ctl.mux_alu_data_y = ALUY_SEXT;
                ctl.dm_op = DM_SW;
            end
            OP_BEQ, OP_BNE: begin
                ctl.rf_ra = 1'b1;
                ctl.rf_rb = 1'b1;
                ctl.alu_op = ALU_SUB;
                ctl.wtg_op = (opcode == OP_BNE) ? WTG_BNE : WTG_BEQ;
            end
            OP_J: begin
                ctl.wtg_op = WTG_J;
            end
            OP_JAL: begin
                ctl.wtg_op = WTG_J;
                ctl.rf_we = 1'b1;
                reqw_sel = REQW_R31;
                ctl.mux_rf_data_w = DATAW_PC8;
            end
            OP_COP0: begin
                case (rs)
                    CP0_MF: begin
                        ctl.rf_we = 1'b1;
                        reqw_sel = REQW_RT;
                        ctl.mux_rf_data_w = DATAW_RC0;
                    end
                    CP0_MT: begin
                        ctl.rf_rb = 1'b1;
                        ctl.rc0_ie_we = ~rd[0];
                        ctl.rc0_epc_we = rd[0];
                    end
                    CP0_CO: begin
                        if (funct == FN_ERET) begin
                            ctl.wtg_op = WTG_ERET;
                            ctl.rc0_op = RC0_RETURN;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        // rd 0 is ie, rd 1 is epc.
        ctl.sel_rc0_epc = rd[0];
    end

    assign is_jump   = ctl.wtg_op inside {WTG_J, WTG_JR, WTG_ERET};
    assign is_branch = ctl.wtg_op inside {WTG_BEQ, WTG_BNE};

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mips_id_settings.svh"

module reg_file import mips_id_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        en,
    input  wire rf_wr_t      wr,
    input  wire logic [4:0]  req_a,
    input  wire logic [4:0]  req_b,
    input  wire logic [4:0]  req_dbg,
    output logic [31:0]      data_a,
    output logic [31:0]      data_b,
    output logic [31:0]      data_dbg
);

    // r0 has no storage.
    logic [31:0] regs [1:`MIPS_ID_NREG-1];

    function automatic logic [31:0] read_port(input logic [4:0] req);
        if (req == 5'd0) begin
            return 32'd0;
        end
        return regs[req];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `MIPS_ID_NREG; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (en && wr.we && wr.req != 5'd0) begin
            regs[wr.req] <= wr.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports, no bypass.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        data_a   = read_port(req_a);
        data_b   = read_port(req_b);
        data_dbg = read_port(req_dbg);
    end

    // Write-back from later stage must name a real register.
    wr_req_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (en && wr.we) |-> !$isunknown(wr.req)
    ) else $error("register write with unknown number");

endmodule

`default_nettype wire

/* logic/irq_cp0.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mips_id_settings.svh"

module irq_cp0 import mips_id_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          en,
    input  wire rc0_wr_t                       wr,
    input  wire logic [`MIPS_ID_NIRQ-1:0]      irq_src,
    output logic [31:0]                        ie,
    output logic [31:0]                        epc,
    output logic                               ivld,
    output logic [`MIPS_ID_NBIT_IRQ-1:0]       inum
);

    logic [`MIPS_ID_NIRQ-1:0]     irq_act;
    logic [`MIPS_ID_NBIT_IRQ-1:0] inum_nxt;
    logic                         ivld_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pending detection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Source i is masked by ie bit i+1.
    assign irq_act  = irq_src & ie[`MIPS_ID_NIRQ:1];
    assign ivld_nxt = ie[0] && (|irq_act);

    // Lowest number wins.
    always_comb begin
        inum_nxt = '0;
        for (int i = `MIPS_ID_NIRQ - 1; i >= 0; i--) begin
            if (irq_act[i]) begin
                inum_nxt = `MIPS_ID_NBIT_IRQ'(i);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ie   <= 32'd0;
            epc  <= 32'd0;
            ivld <= 1'b0;
            inum <= '0;
        end else if (en) begin
            // Direct write beats enter and return.
            if (wr.ie_we) begin
                ie <= wr.ie;
            end else if (wr.op == RC0_ENTER) begin
                ie[0] <= 1'b0;
            end else if (wr.op == RC0_RETURN) begin
                ie[0] <= 1'b1;
            end
            if (wr.epc_we) begin
                epc <= wr.epc;
            end
            ivld <= ivld_nxt;
            inum <= inum_nxt;
        end
    end

    // Reported source was really raised when it was sampled.
    inum_was_active: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ivld && $past(en)) |->
            |(`MIPS_ID_NIRQ'(1) & ($past(irq_src) >> inum))
    ) else $error("ivld set for a source that was not active");

endmodule

`default_nettype wire

/* logic/id_stage.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mips_id_settings.svh"

module id_stage import mips_id_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          en,
    input  wire logic [31:0]                   inst,
    input  wire logic [`MIPS_ID_NIRQ-1:0]      irq_src,
    input  wire logic [4:0]                    dbg_rf_req,
    input  wire rf_wr_t                        prv_rf,
    input  wire rc0_wr_t                       prv_rc0,
    output logic [31:0]                        dbg_rf_data,
    output logic [4:0]                         shamt,
    output logic [15:0]                        imm16,
    output logic [31:0]                        rf_data_a,
    output logic [31:0]                        rf_data_b,
    output logic [4:0]                         req_w,
    output logic [4:0]                         req_a,
    output logic [4:0]                         req_b,
    output ctrl_t                              ctl,
    output logic [31:0]                        rc0_ie,
    output logic [31:0]                        rc0_epc,
    output logic                               rc0_ivld,
    output logic [`MIPS_ID_NBIT_IRQ-1:0]       rc0_inum,
    output logic                               is_jump,
    output logic                               is_branch
);

    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    reqw_sel_e  reqw_sel;

    ctrl_decode ctrl_decode_inst (
        .inst      (inst),
        .rs        (rs),
        .rt        (rt),
        .rd        (rd),
        .shamt     (shamt),
        .imm16     (imm16),
        .ctl       (ctl),
        .reqw_sel  (reqw_sel),
        .is_jump   (is_jump),
        .is_branch (is_branch)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register number selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (reqw_sel)
            REQW_RD:  req_w = rd;
            REQW_RT:  req_w = rt;
            REQW_R31: req_w = 5'd31;
            default:  req_w = 5'd0;
        endcase
        // Syscall reads its arguments from fixed registers.
        if (ctl.syscall_en) begin
            req_a = `MIPS_ID_SYSCALL_RA;
            req_b = `MIPS_ID_SYSCALL_RB;
        end else begin
            req_a = rs;
            req_b = rt;
        end
    end

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .wr       (prv_rf),
        .req_a    (req_a),
        .req_b    (req_b),
        .req_dbg  (dbg_rf_req),
        .data_a   (rf_data_a),
        .data_b   (rf_data_b),
        .data_dbg (dbg_rf_data)
    );

    irq_cp0 irq_cp0_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .wr      (prv_rc0),
        .irq_src (irq_src),
        .ie      (rc0_ie),
        .epc     (rc0_epc),
        .ivld    (rc0_ivld),
        .inum    (rc0_inum)
    );

endmodule

`default_nettype wire

/* verification/id_stage_tests.svh */
`ifndef ID_STAGE_TESTS_SVH
`define ID_STAGE_TESTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic reg_write_read();
    int          start;
    logic [4:0]  req;
    logic [4:0]  prev;
    logic [31:0] data;
    start = errors;
    prev = 5'd0;
    for (int n = 0; n < 6; n++) begin
        data = next_random();
        req = data[4:0];
        write_reg(req, next_random());
        read_regs(req, prev);
        prev = req;
    end
    write_reg(5'd0, next_random());
    read_regs(5'd0, prev);
    // Stalled stage drops the strobe.
    @(posedge clk);
    en <= 1'b0;
    write_reg(5'd7, 32'hdead_beef);
    @(posedge clk);
    en <= 1'b1;
    read_regs(5'd7, prev);
    finish_test("register write and read", start);
endtask

task automatic decode_classes();
    int start;
    start = errors;
    check_decode("nop", 32'd0, 5'd0, 2'b00,
        make_ctl(3'b011, ALU_SLL, ALUY_SHAMT, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("add", r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'h20), 5'd3, 2'b00,
        make_ctl(3'b111, ALU_ADD, ALUY_REGB, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("srl", r_type(5'd0, 5'd6, 5'd5, 5'd4, 6'h02), 5'd5, 2'b00,
        make_ctl(3'b011, ALU_SRL, ALUY_SHAMT, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("ori", i_type(6'h0d, 5'd1, 5'd7, 16'h8001), 5'd7, 2'b00,
        make_ctl(3'b101, ALU_OR, ALUY_ZEXT, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("lui", i_type(6'h0f, 5'd0, 5'd12, 16'h1234), 5'd12, 2'b00,
        make_ctl(3'b001, ALU_LUI, ALUY_ZEXT, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("lw", i_type(6'h23, 5'd1, 5'd9, 16'h0004), 5'd9, 2'b00,
        make_ctl(3'b101, ALU_ADD, ALUY_SEXT, WTG_SEQ, DM_LW, DATAW_MEM, 2'b00, RC0_NONE));
    check_decode("sw", i_type(6'h2b, 5'd1, 5'd9, 16'h0008), 5'd0, 2'b00,
        make_ctl(3'b110, ALU_ADD, ALUY_SEXT, WTG_SEQ, DM_SW, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("beq", i_type(6'h04, 5'd1, 5'd2, 16'h0010), 5'd0, 2'b01,
        make_ctl(3'b110, ALU_SUB, ALUY_REGB, WTG_BEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("bne", i_type(6'h05, 5'd3, 5'd4, 16'hfffc), 5'd0, 2'b01,
        make_ctl(3'b110, ALU_SUB, ALUY_REGB, WTG_BNE, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("j", i_type(6'h02, 5'd0, 5'd0, 16'h0100), 5'd0, 2'b10,
        make_ctl(3'b000, ALU_ADD, ALUY_REGB, WTG_J, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("jal", i_type(6'h03, 5'd0, 5'd0, 16'h0840), 5'd31, 2'b10,
        make_ctl(3'b001, ALU_ADD, ALUY_REGB, WTG_J, DM_NONE, DATAW_PC8, 2'b00, RC0_NONE));
    check_decode("jr", r_type(5'd31, 5'd0, 5'd0, 5'd0, 6'h08), 5'd0, 2'b10,
        make_ctl(3'b100, ALU_ADD, ALUY_REGB, WTG_JR, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    check_decode("mfc0", i_type(6'h10, 5'h00, 5'd10, 16'h0800), 5'd10, 2'b00,
        make_ctl(3'b001, ALU_ADD, ALUY_REGB, WTG_SEQ, DM_NONE, DATAW_RC0, 2'b00, RC0_NONE));
    check_decode("mtc0", i_type(6'h10, 5'h04, 5'd11, 16'h0800), 5'd0, 2'b00,
        make_ctl(3'b010, ALU_ADD, ALUY_REGB, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b01, RC0_NONE));
    check_decode("eret", i_type(6'h10, 5'h10, 5'd0, 16'h0018), 5'd0, 2'b10,
        make_ctl(3'b000, ALU_ADD, ALUY_REGB, WTG_ERET, DM_NONE, DATAW_ALU, 2'b00, RC0_RETURN));
    check_decode("unknown", 32'hfc00_0000, 5'd0, 2'b00,
        make_ctl(3'b000, ALU_ADD, ALUY_REGB, WTG_SEQ, DM_NONE, DATAW_ALU, 2'b00, RC0_NONE));
    finish_test("instruction decode", start);
endtask

task automatic syscall_operands();
    int start;
    start = errors;
    write_reg(`MIPS_ID_SYSCALL_RA, next_random());
    write_reg(`MIPS_ID_SYSCALL_RB, next_random());
    @(posedge clk);
    inst <= r_type(5'd7, 5'd9, 5'd0, 5'd0, 6'h0c);
    @(negedge clk);
    compare_value("syscall_en", ctl.syscall_en, 1'b1);
    compare_value("syscall req_a", req_a, `MIPS_ID_SYSCALL_RA);
    compare_value("syscall req_b", req_b, `MIPS_ID_SYSCALL_RB);
    compare_value("syscall operand a", rf_data_a, rf_model[`MIPS_ID_SYSCALL_RA]);
    compare_value("syscall operand b", rf_data_b, rf_model[`MIPS_ID_SYSCALL_RB]);
    finish_test("syscall operands", start);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt coprocessor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic irq_detection();
    int          start;
    logic [31:0] data;
    start = errors;
    rc0_update(RC0_NONE, 1'b1, {23'd0, 8'hac, 1'b1}, 1'b0, 32'd0);
    check_irq("several unmasked", 8'he6);
    check_irq("none unmasked", 8'h53);
    rc0_update(RC0_NONE, 1'b1, {23'd0, 8'hac, 1'b0}, 1'b0, 32'd0);
    check_irq("global enable off", 8'hff);
    rc0_update(RC0_NONE, 1'b1, 32'h0000_0001, 1'b0, 32'd0);
    check_irq("all masked", 8'hff);
    data = next_random();
    rc0_update(RC0_NONE, 1'b1, {23'd0, data[8:1], 1'b1}, 1'b0, 32'd0);
    check_irq("random sources", data[31:24]);
    @(posedge clk);
    irq_src <= '0;
    finish_test("interrupt detection", start);
endtask

task automatic enter_and_return();
    int start;
    start = errors;
    rc0_update(RC0_NONE, 1'b0, 32'd0, 1'b1, next_random());
    rc0_update(RC0_NONE, 1'b1, 32'h0000_001f, 1'b0, 32'd0);
    rc0_update(RC0_ENTER, 1'b0, 32'd0, 1'b0, 32'd0);
    compare_value("enter global enable", rc0_ie, 32'h0000_001e);
    rc0_update(RC0_RETURN, 1'b0, 32'd0, 1'b0, 32'd0);
    compare_value("return global enable", rc0_ie, 32'h0000_001f);
    // Direct write beats enter.
    rc0_update(RC0_ENTER, 1'b1, 32'h0000_0031, 1'b0, 32'd0);
    compare_value("direct ie write", rc0_ie, 32'h0000_0031);
    finish_test("enter and return", start);
endtask

task automatic reset_state();
    int start;
    start = errors;
    rc0_update(RC0_NONE, 1'b1, 32'h0000_01ff, 1'b1, 32'h0000_0400);
    @(posedge clk);
    irq_src <= 8'h01;
    apply_reset();
    @(negedge clk);
    compare_value("rc0_ie after reset", rc0_ie, 32'd0);
    compare_value("rc0_epc after reset", rc0_epc, 32'd0);
    compare_value("rc0_ivld after reset", rc0_ivld, 1'b0);
    for (int i = 0; i < 32; i++) begin
        @(posedge clk);
        irq_src <= '0;
        dbg_rf_req <= 5'(i);
        @(negedge clk);
        compare_value("register after reset", dbg_rf_data, 32'd0);
    end
    finish_test("reset state", start);
endtask

`endif

/* verification/id_stage_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mips_id_settings.svh"

module id_stage_tb import mips_id_pkg::*; ();

    localparam int CYCLE_LIMIT = 400;

    logic                          clk;
    logic                          rst_n;
    logic                          en;
    logic [31:0]                   inst;
    logic [`MIPS_ID_NIRQ-1:0]      irq_src;
    logic [4:0]                    dbg_rf_req;
    rf_wr_t                        prv_rf;
    rc0_wr_t                       prv_rc0;
    logic [31:0]                   dbg_rf_data;
    logic [4:0]                    shamt;
    logic [15:0]                   imm16;
    logic [31:0]                   rf_data_a;
    logic [31:0]                   rf_data_b;
    logic [4:0]                    req_w;
    logic [4:0]                    req_a;
    logic [4:0]                    req_b;
    ctrl_t                         ctl;
    logic [31:0]                   rc0_ie;
    logic [31:0]                   rc0_epc;
    logic                          rc0_ivld;
    logic [`MIPS_ID_NBIT_IRQ-1:0]  rc0_inum;
    logic                          is_jump;
    logic                          is_branch;

    // Expected state rebuilt from the write-back traffic.
    logic [31:0] rf_model [0:31];
    logic [31:0] ie_model;
    logic [31:0] epc_model;
    logic [31:0] rng_state;
    int          cycles = 0;
    int          errors;
    int          tests;

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and check helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
            input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // rd_wr is {rf_ra, rf_rb, rf_we} and rc0_we is {ie_we, epc_we}.
    function automatic ctrl_t make_ctl(input logic [2:0] rd_wr, input alu_op_e alu,
            input aluy_sel_e alu_y, input wtg_op_e wtg, input dm_op_e dm,
            input dataw_sel_e data_w, input logic [1:0] rc0_we, input rc0_op_e rc0);
        ctrl_t c;
        c = '0;
        c.rf_ra = rd_wr[2];
        c.rf_rb = rd_wr[1];
        c.rf_we = rd_wr[0];
        c.alu_op = alu;
        c.mux_alu_data_y = alu_y;
        c.wtg_op = wtg;
        c.dm_op = dm;
        c.mux_rf_data_w = data_w;
        c.rc0_ie_we = rc0_we[1];
        c.rc0_epc_we = rc0_we[0];
        c.rc0_op = rc0;
        return c;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = 32'd0;
        end
        ie_model = 32'd0;
        epc_model = 32'd0;
    endtask

    // One-cycle write strobe. Old value must still show before the edge.
    task automatic write_reg(input logic [4:0] req, input logic [31:0] data);
        rf_wr_t wr;
        wr.we = 1'b1;
        wr.req = req;
        wr.data = data;
        @(posedge clk);
        prv_rf <= wr;
        dbg_rf_req <= req;
        @(negedge clk);
        compare_value("debug read before write", dbg_rf_data, rf_model[req]);
        @(posedge clk);
        prv_rf.we <= 1'b0;
        if (en && req != 5'd0) begin
            rf_model[req] = data;
        end
    endtask

    task automatic read_regs(input logic [4:0] a, input logic [4:0] b);
        @(posedge clk);
        inst <= r_type(a, b, 5'd0, 5'd0, 6'h20);
        dbg_rf_req <= a;
        @(negedge clk);
        compare_value("operand a", rf_data_a, rf_model[a]);
        compare_value("operand b", rf_data_b, rf_model[b]);
        compare_value("debug read", dbg_rf_data, rf_model[a]);
    endtask

    task automatic check_decode(input string name, input logic [31:0] word,
            input logic [4:0] exp_req_w, input logic [1:0] jump_branch, input ctrl_t exp);
        ctrl_t want;
        want = exp;
        // Bit 0 of rd picks epc over ie.
        want.sel_rc0_epc = word[11];
        @(posedge clk);
        inst <= word;
        @(negedge clk);
        compare_value({name, " ctl"}, ctl, want);
        compare_value({name, " req_w"}, req_w, exp_req_w);
        compare_value({name, " is_jump"}, is_jump, jump_branch[1]);
        compare_value({name, " is_branch"}, is_branch, jump_branch[0]);
        compare_value({name, " shamt"}, shamt, word[10:6]);
        compare_value({name, " imm16"}, imm16, word[15:0]);
    endtask

    task automatic rc0_update(input rc0_op_e op, input logic ie_we, input logic [31:0] ie,
            input logic epc_we, input logic [31:0] epc);
        rc0_wr_t wr;
        wr.op = op;
        wr.ie_we = ie_we;
        wr.epc_we = epc_we;
        wr.ie = ie;
        wr.epc = epc;
        @(posedge clk);
        prv_rc0 <= wr;
        @(posedge clk);
        prv_rc0 <= '0;
        if (ie_we) begin
            ie_model = ie;
        end else if (op == RC0_ENTER) begin
            ie_model[0] = 1'b0;
        end else if (op == RC0_RETURN) begin
            ie_model[0] = 1'b1;
        end
        if (epc_we) begin
            epc_model = epc;
        end
        @(negedge clk);
        compare_value("rc0_ie", rc0_ie, ie_model);
        compare_value("rc0_epc", rc0_epc, epc_model);
    endtask

    task automatic check_irq(input string name, input logic [`MIPS_ID_NIRQ-1:0] src);
        logic                         exp_vld;
        logic [`MIPS_ID_NBIT_IRQ-1:0] exp_num;
        exp_vld = 1'b0;
        exp_num = '0;
        // Source i is gated by ie bit i+1 and the lowest number wins.
        for (int i = 0; i < `MIPS_ID_NIRQ; i++) begin
            if (!exp_vld && ie_model[0] && src[i] && ie_model[i + 1]) begin
                exp_vld = 1'b1;
                exp_num = `MIPS_ID_NBIT_IRQ'(i);
            end
        end
        @(posedge clk);
        irq_src <= src;
        @(posedge clk);
        @(negedge clk);
        compare_value({name, " rc0_ivld"}, rc0_ivld, exp_vld);
        if (exp_vld) begin
            compare_value({name, " rc0_inum"}, rc0_inum, exp_num);
        end
    endtask

    `include "id_stage_tests.svh"

    initial begin
        rst_n = 1'b0;
        en = 1'b1;
        inst = 32'd0;
        irq_src = '0;
        dbg_rf_req = 5'd0;
        prv_rf = '0;
        prv_rc0 = '0;
        rng_state = 32'he44a_efbf;
        errors = 0;
        tests = 0;
        apply_reset();
        reg_write_read();
        decode_classes();
        syscall_operands();
        irq_detection();
        enter_and_return();
        reset_state();
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_id.f */
+incdir+logic
+incdir+verification
logic/mips_id_pkg.sv
logic/ctrl_decode.sv
logic/reg_file.sv
logic/irq_cp0.sv
logic/id_stage.sv
verification/id_stage_tb.sv

/* Bender.yml */
package:
  name: mips_id

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_id_pkg.sv
      - logic/ctrl_decode.sv
      - logic/reg_file.sv
      - logic/irq_cp0.sv
      - logic/id_stage.sv
  - target: test
    include_dirs:
      - logic
      - verification
    files:
      - verification/id_stage_tb.sv
